//--- common/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// address map
`define RTC_PORT_ADDR 32'ha000_0048
`define RTC_PORT_SIZE 32'd8

// axi response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

// field widths
`define ADDR_W      32
`define DATA_W      32
`define STRB_W      4
`define RESP_W      2
`define LEN_W       8
`define AXI_SIZE_W  3
`define AXI_BURST_W 2

`endif

//--- common/axi_pkg.sv
`include "soc_config.svh"

package axi_pkg;

	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [`STRB_W-1:0] strb_t;
	typedef logic [`RESP_W-1:0] resp_t;
	// burst length minus one
	typedef logic [`LEN_W-1:0]  len_t;

	// read address, master to slave
	typedef struct packed {
		addr_t                   araddr;
		logic [`AXI_SIZE_W-1:0]  arsize;
		len_t                    arlen;
		logic [`AXI_BURST_W-1:0] arburst;
		logic                    arvalid;
	} ar_req_t;

	// read data, slave to master
	typedef struct packed {
		data_t rdata;
		resp_t rresp;
		logic  rlast;
		logic  rvalid;
	} r_resp_t;

	typedef struct packed {
		addr_t awaddr;
		logic  awvalid;
	} aw_req_t;

	typedef struct packed {
		data_t wdata;
		strb_t wstrb;
		logic  wvalid;
	} w_req_t;

	typedef struct packed {
		resp_t bresp;
		logic  bvalid;
	} b_resp_t;

	// read route held by the crossbar
	typedef enum logic [1:0] {
		IDLE,
		ROUTE_SOC,
		ROUTE_RTC
	} xbar_state_t;

	// owner of the shared read path
	typedef enum logic [1:0] {
		ARB_IDLE,
		GRANT_IFU,
		GRANT_LSU
	} arb_state_t;

endpackage

//--- arbiter/axi_read_arbiter.sv
`timescale 1ns/1ns

module axi_read_arbiter
	import axi_pkg::*;
(
	input  logic    clk,
	input  logic    rst,

	// instruction fetch master
	input  ar_req_t ifu_ar,
	output logic    ifu_arready,
	output r_resp_t ifu_r,
	input  logic    ifu_rready,

	// load/store master
	input  ar_req_t lsu_ar,
	output logic    lsu_arready,
	output r_resp_t lsu_r,
	input  logic    lsu_rready,

	// shared path toward the crossbar
	output ar_req_t xbar_ar,
	input  logic    xbar_arready,
	input  r_resp_t xbar_r,
	output logic    xbar_rready
);

	arb_state_t state;
	arb_state_t next_state;

	logic    granted;
	logic    ar_done;
	logic    ar_accept;
	logic    last_beat;
	ar_req_t sel_ar;
	logic    sel_rready;

	assign granted = (state != ARB_IDLE);

	// the granted master's request and ready
	assign sel_ar     = (state == GRANT_LSU) ? lsu_ar : ifu_ar;
	assign sel_rready = (state == GRANT_LSU) ? lsu_rready : ifu_rready;

	// one address per grant, further requests wait for the release
	assign ar_accept = granted && !ar_done && xbar_arready;
	assign last_beat = xbar_r.rvalid && xbar_rready && xbar_r.rlast;

	always_comb begin
		next_state = state;
		case (state)
			ARB_IDLE: begin
				// lsu wins a tie
				if (lsu_ar.arvalid) begin
					next_state = GRANT_LSU;
				end else if (ifu_ar.arvalid) begin
					next_state = GRANT_IFU;
				end
			end
			GRANT_IFU, GRANT_LSU: begin
				if (last_beat) begin
					next_state = ARB_IDLE;
				end
			end
			default: next_state = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= ARB_IDLE;
			ar_done <= 1'b0;
		end else begin
			state <= next_state;
			if (!granted || last_beat) begin
				ar_done <= 1'b0;
			end else if (xbar_ar.arvalid && xbar_arready) begin
				ar_done <= 1'b1;
			end
		end
	end

	always_comb begin
		xbar_ar     = '0;
		xbar_rready = 1'b0;
		if (granted) begin
			xbar_ar         = sel_ar;
			xbar_ar.arvalid = sel_ar.arvalid && !ar_done;
			xbar_rready     = sel_rready;
		end
	end

	// the loser sees no ready and no response
	assign ifu_arready = ar_accept && (state == GRANT_IFU);
	assign lsu_arready = ar_accept && (state == GRANT_LSU);
	assign ifu_r       = (state == GRANT_IFU) ? xbar_r : '0;
	assign lsu_r       = (state == GRANT_LSU) ? xbar_r : '0;

endmodule

//--- xbar/axi_xbar.sv
`timescale 1ns/1ns

`include "soc_config.svh"

module axi_xbar
	import axi_pkg::*;
(
	input  logic    clk,
	input  logic    rst,

	// upstream, from the arbiter and the lsu write path
	input  ar_req_t ar,
	output logic    arready,
	output r_resp_t r,
	input  logic    rready,
	input  aw_req_t aw,
	output logic    awready,
	input  w_req_t  w,
	output logic    wready,
	output b_resp_t b,
	input  logic    bready,

	// soc bus
	output ar_req_t soc_ar,
	input  logic    soc_arready,
	input  r_resp_t soc_r,
	output logic    soc_rready,
	output aw_req_t soc_aw,
	input  logic    soc_awready,
	output w_req_t  soc_w,
	input  logic    soc_wready,
	input  b_resp_t soc_b,
	output logic    soc_bready,

	// rtc, read only
	output ar_req_t rtc_ar,
	input  logic    rtc_arready,
	input  r_resp_t rtc_r,
	output logic    rtc_rready
);

	xbar_state_t state;
	xbar_state_t next_state;

	logic hit_rtc;

	// rtc window decode
	assign hit_rtc = (ar.araddr >= `RTC_PORT_ADDR) &&
		(ar.araddr < `RTC_PORT_ADDR + `RTC_PORT_SIZE);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (ar.arvalid) begin
					next_state = hit_rtc ? ROUTE_RTC : ROUTE_SOC;
				end
			end
			ROUTE_SOC: begin
				if (soc_r.rvalid && rready && soc_r.rlast) begin
					next_state = IDLE;
				end
			end
			ROUTE_RTC: begin
				// the rtc answers with a single beat
				if (rtc_r.rvalid && rready) begin
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// read steering, idle slave sees all zeros
	always_comb begin
		arready    = 1'b0;
		r          = '0;
		soc_ar     = '0;
		soc_rready = 1'b0;
		rtc_ar     = '0;
		rtc_rready = 1'b0;
		case (state)
			ROUTE_SOC: begin
				soc_ar     = ar;
				arready    = soc_arready;
				r          = soc_r;
				soc_rready = rready;
			end
			ROUTE_RTC: begin
				rtc_ar     = ar;
				arready    = rtc_arready;
				r          = rtc_r;
				r.rlast    = 1'b1;
				rtc_rready = rready;
			end
			default: begin
				arready = 1'b0;
			end
		endcase
	end

	// write channels go straight to the soc bus
	assign soc_aw     = aw;
	assign awready    = soc_awready;
	assign soc_w      = w;
	assign wready     = soc_wready;
	assign b          = soc_b;
	assign soc_bready = bready;

endmodule

//--- verilog/rtc_timer.sv
`timescale 1ns/1ns

`include "soc_config.svh"

module rtc_timer
	import axi_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  ar_req_t ar,
	output logic    arready,
	output r_resp_t r,
	input  logic    rready
);

	logic [63:0] count;
	data_t       shadow_hi;
	data_t       rdata;
	logic        busy;
	addr_t       offset;
	logic        ar_fire;

	// free running cycle counter
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count + 64'd1;
		end
	end

	assign offset  = ar.araddr - `RTC_PORT_ADDR;
	assign arready = !busy;
	assign ar_fire = ar.arvalid && arready;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (ar_fire) begin
			busy <= 1'b1;
		end else if (busy && rready) begin
			busy <= 1'b0;
		end
	end

	// low word read latches the upper half so a later high read matches it
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			if (offset[2]) begin
				rdata <= shadow_hi;
			end else begin
				rdata     <= count[31:0];
				shadow_hi <= count[63:32];
			end
		end
	end

	assign r.rdata  = rdata;
	assign r.rresp  = `RESP_OKAY;
	assign r.rlast  = 1'b1;
	assign r.rvalid = busy;

endmodule

//--- verilog/mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top
	import axi_pkg::*;
(
	input  logic    clk,
	input  logic    rst,

	// instruction fetch master, read only
	input  ar_req_t ifu_ar,
	output logic    ifu_arready,
	output r_resp_t ifu_r,
	input  logic    ifu_rready,

	// load/store master
	input  ar_req_t lsu_ar,
	output logic    lsu_arready,
	output r_resp_t lsu_r,
	input  logic    lsu_rready,
	input  aw_req_t lsu_aw,
	output logic    lsu_awready,
	input  w_req_t  lsu_w,
	output logic    lsu_wready,
	output b_resp_t lsu_b,
	input  logic    lsu_bready,

	// external soc bus
	output ar_req_t soc_ar,
	input  logic    soc_arready,
	input  r_resp_t soc_r,
	output logic    soc_rready,
	output aw_req_t soc_aw,
	input  logic    soc_awready,
	output w_req_t  soc_w,
	input  logic    soc_wready,
	input  b_resp_t soc_b,
	output logic    soc_bready
);

	ar_req_t xbar_ar;
	logic    xbar_arready;
	r_resp_t xbar_r;
	logic    xbar_rready;

	ar_req_t rtc_ar;
	logic    rtc_arready;
	r_resp_t rtc_r;
	logic    rtc_rready;

	axi_read_arbiter u_arbiter (
		.clk          (clk),
		.rst          (rst),
		.ifu_ar       (ifu_ar),
		.ifu_arready  (ifu_arready),
		.ifu_r        (ifu_r),
		.ifu_rready   (ifu_rready),
		.lsu_ar       (lsu_ar),
		.lsu_arready  (lsu_arready),
		.lsu_r        (lsu_r),
		.lsu_rready   (lsu_rready),
		.xbar_ar      (xbar_ar),
		.xbar_arready (xbar_arready),
		.xbar_r       (xbar_r),
		.xbar_rready  (xbar_rready)
	);

	axi_xbar u_xbar (
		.clk         (clk),
		.rst         (rst),
		.ar          (xbar_ar),
		.arready     (xbar_arready),
		.r           (xbar_r),
		.rready      (xbar_rready),
		.aw          (lsu_aw),
		.awready     (lsu_awready),
		.w           (lsu_w),
		.wready      (lsu_wready),
		.b           (lsu_b),
		.bready      (lsu_bready),
		.soc_ar      (soc_ar),
		.soc_arready (soc_arready),
		.soc_r       (soc_r),
		.soc_rready  (soc_rready),
		.soc_aw      (soc_aw),
		.soc_awready (soc_awready),
		.soc_w       (soc_w),
		.soc_wready  (soc_wready),
		.soc_b       (soc_b),
		.soc_bready  (soc_bready),
		.rtc_ar      (rtc_ar),
		.rtc_arready (rtc_arready),
		.rtc_r       (rtc_r),
		.rtc_rready  (rtc_rready)
	);

	rtc_timer u_rtc (
		.clk     (clk),
		.rst     (rst),
		.ar      (rtc_ar),
		.arready (rtc_arready),
		.r       (rtc_r),
		.rready  (rtc_rready)
	);

endmodule

//--- testbench/mem_subsys_assert.sv
`timescale 1ns/1ns

`include "soc_config.svh"

module mem_subsys_assert
	import axi_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input ar_req_t soc_ar,
	input logic    soc_arready,
	input ar_req_t rtc_ar,
	input logic    rtc_arready,
	input r_resp_t r,
	input b_resp_t b
);

	// one slave at a time
	one_slave: assert property (@(posedge clk) disable iff (rst)
		!(soc_ar.arvalid && rtc_ar.arvalid))
		else $error("soc and rtc address valid together");

	soc_ar_stable: assert property (@(posedge clk) disable iff (rst)
		soc_ar.arvalid && !soc_arready |=> soc_ar.arvalid && $stable(soc_ar.araddr)
		&& $stable(soc_ar.arlen))
		else $error("soc read address changed before handshake");

	rtc_ar_stable: assert property (@(posedge clk) disable iff (rst)
		rtc_ar.arvalid && !rtc_arready |=> rtc_ar.arvalid && $stable(rtc_ar.araddr))
		else $error("rtc read address changed before handshake");

	// responses as they leave the crossbar
	resp_okay: assert property (@(posedge clk) disable iff (rst)
		(!r.rvalid || r.rresp == `RESP_OKAY) && (!b.bvalid || b.bresp == `RESP_OKAY))
		else $error("response code not okay");

	rtc_window: assert property (@(posedge clk) disable iff (rst)
		rtc_ar.arvalid |-> (rtc_ar.araddr >= `RTC_PORT_ADDR)
		&& (rtc_ar.araddr < `RTC_PORT_ADDR + `RTC_PORT_SIZE))
		else $error("rtc selected outside its window");

endmodule

bind axi_xbar mem_subsys_assert u_assert (
	.clk         (clk),
	.rst         (rst),
	.soc_ar      (soc_ar),
	.soc_arready (soc_arready),
	.rtc_ar      (rtc_ar),
	.rtc_arready (rtc_arready),
	.r           (r),
	.b           (b)
);

//--- testbench/tb_mem_subsys.sv
`timescale 1ns/1ns

`include "soc_config.svh"

module tb_mem_subsys
	import axi_pkg::*;
();

	localparam int LIMIT = 200;
	localparam int N_OPS = 12;
	localparam int MEM_WORDS = 256;

	logic clk;
	logic rst;

	// index 0 is the fetch master and index 1 the load/store master
	ar_req_t mst_ar [2];
	logic    mst_arready [2];
	r_resp_t mst_r [2];
	logic    mst_rready [2];
	aw_req_t lsu_aw;
	logic    lsu_awready;
	w_req_t  lsu_w;
	logic    lsu_wready;
	b_resp_t lsu_b;
	logic    lsu_bready;

	ar_req_t soc_ar;
	logic    soc_arready;
	r_resp_t soc_r;
	logic    soc_rready;
	aw_req_t soc_aw;
	logic    soc_awready;
	w_req_t  soc_w;
	logic    soc_wready;
	b_resp_t soc_b;
	logic    soc_bready;

	data_t mem [MEM_WORDS];
	data_t shadow [MEM_WORDS];
	integer seed;
	int errors;
	int checks;
	logic timed_out;
	int cyc;
	int first_beat [2];
	data_t rtc_lo;
	logic [63:0] prev_rtc;

	// operation table
	logic  op_write [N_OPS];
	int    op_master [N_OPS];
	addr_t op_addr [N_OPS];
	len_t  op_len [N_OPS];
	data_t op_data [N_OPS];
	strb_t op_strb [N_OPS];
	logic  op_both [N_OPS];

	// soc model state
	logic  s_ar_hs;
	logic  s_r_hs;
	logic  s_aw_hs;
	logic  s_w_hs;
	logic  s_b_hs;
	addr_t c_ar_addr;
	addr_t c_aw_addr;
	addr_t rd_addr;
	addr_t aw_addr;
	len_t  c_ar_len;
	len_t  rd_left;
	data_t c_w_data;
	data_t w_data;
	strb_t c_w_strb;
	strb_t w_strb;
	logic  rd_busy;
	logic  aw_got;
	logic  w_got;
	logic  b_pend;

	mem_subsys_top u_dut (
		.clk         (clk),
		.rst         (rst),
		.ifu_ar      (mst_ar[0]),
		.ifu_arready (mst_arready[0]),
		.ifu_r       (mst_r[0]),
		.ifu_rready  (mst_rready[0]),
		.lsu_ar      (mst_ar[1]),
		.lsu_arready (mst_arready[1]),
		.lsu_r       (mst_r[1]),
		.lsu_rready  (mst_rready[1]),
		.lsu_aw      (lsu_aw),
		.lsu_awready (lsu_awready),
		.lsu_w       (lsu_w),
		.lsu_wready  (lsu_wready),
		.lsu_b       (lsu_b),
		.lsu_bready  (lsu_bready),
		.soc_ar      (soc_ar),
		.soc_arready (soc_arready),
		.soc_r       (soc_r),
		.soc_rready  (soc_rready),
		.soc_aw      (soc_aw),
		.soc_awready (soc_awready),
		.soc_w       (soc_w),
		.soc_wready  (soc_wready),
		.soc_b       (soc_b),
		.soc_bready  (soc_bready)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	// fill pattern over the full byte address
	function automatic data_t fill_word(input addr_t a);
		return (a * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t s);
		data_t res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (s[b]) begin
				res[b*8 +: 8] = nw[b*8 +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic in_rtc(input addr_t a);
		return (a >= `RTC_PORT_ADDR) && (a < `RTC_PORT_ADDR + `RTC_PORT_SIZE);
	endfunction

	task automatic note_timeout(input string what);
		if (!timed_out) begin
			$display("timeout: no %s within %0d cycles", what, LIMIT);
		end
		timed_out = 1'b1;
	endtask

	task automatic set_op(input int i, input logic wr, input int m, input addr_t a,
		input len_t l, input data_t d, input strb_t s, input logic both);
		op_write[i]  = wr;
		op_master[i] = m;
		op_addr[i]   = a;
		op_len[i]    = l;
		op_data[i]   = d;
		op_strb[i]   = s;
		op_both[i]   = both;
	endtask

	// soc slave handshakes seen at mid cycle take effect after the next edge
	always @(negedge clk) begin
		s_ar_hs = soc_ar.arvalid && soc_arready;
		s_r_hs  = soc_r.rvalid && soc_rready;
		s_aw_hs = soc_aw.awvalid && soc_awready;
		s_w_hs  = soc_w.wvalid && soc_wready;
		s_b_hs  = soc_b.bvalid && soc_bready;
		c_ar_addr = soc_ar.araddr;
		c_ar_len  = soc_ar.arlen;
		c_aw_addr = soc_aw.awaddr;
		c_w_data  = soc_w.wdata;
		c_w_strb  = soc_w.wstrb;
	end

	always @(posedge clk) begin
		#2;
		if (rst) begin
			rd_busy = 1'b0;
			aw_got  = 1'b0;
			w_got   = 1'b0;
			b_pend  = 1'b0;
		end else begin
			if (s_ar_hs) begin
				rd_busy = 1'b1;
				rd_addr = c_ar_addr;
				rd_left = c_ar_len;
			end else if (s_r_hs) begin
				if (rd_left == 0) begin
					rd_busy = 1'b0;
				end else begin
					rd_addr = rd_addr + 32'd4;
					rd_left = rd_left - 1'b1;
				end
			end
			if (s_aw_hs) begin
				aw_got  = 1'b1;
				aw_addr = c_aw_addr;
			end
			if (s_w_hs) begin
				w_got  = 1'b1;
				w_data = c_w_data;
				w_strb = c_w_strb;
			end
			if (s_b_hs) begin
				b_pend = 1'b0;
			end
			if (aw_got && w_got && !b_pend) begin
				mem[aw_addr[9:2]] = merge_bytes(mem[aw_addr[9:2]], w_data, w_strb);
				aw_got = 1'b0;
				w_got  = 1'b0;
				b_pend = 1'b1;
			end
		end
		soc_arready    = !rd_busy && ($random(seed) & 1) != 0;
		soc_awready    = !aw_got && ($random(seed) & 1) != 0;
		soc_wready     = !w_got && ($random(seed) & 1) != 0;
		soc_r.rvalid   = rd_busy;
		soc_r.rdata    = mem[rd_addr[9:2]];
		soc_r.rresp    = `RESP_OKAY;
		soc_r.rlast    = (rd_left == 0);
		soc_b.bvalid   = b_pend;
		soc_b.bresp    = `RESP_OKAY;
	end

	task automatic check_rtc(input data_t hi);
		logic [63:0] combined;
		combined = {hi, rtc_lo};
		checks++;
		if (combined == 64'd0 || combined >= 64'(cyc) || combined <= prev_rtc) begin
			$display("ERROR at %0t: rtc reading %0d, cycles %0d, previous %0d",
				$time, combined, cyc, prev_rtc);
			errors++;
		end
		prev_rtc = combined;
	endtask

	task automatic read_op(input int m, input addr_t addr, input len_t len);
		int n;
		int cnt;
		int idx;
		logic done;
		data_t exp;
		idx = int'(addr[9:2]);
		@(posedge clk);
		#2;
		mst_ar[m].araddr  = addr;
		mst_ar[m].arsize  = 3'd2;
		mst_ar[m].arlen   = len;
		mst_ar[m].arburst = 2'b01;
		mst_ar[m].arvalid = 1'b1;
		cnt = 0;
		done = 1'b0;
		while (!done && !timed_out) begin
			@(negedge clk);
			done = mst_ar[m].arvalid && mst_arready[m];
			cnt++;
			if (cnt > LIMIT) begin
				note_timeout("read address handshake");
			end
		end
		@(posedge clk);
		#2;
		mst_ar[m].arvalid = 1'b0;
		mst_rready[m] = ($random(seed) & 3) != 0;
		n = 0;
		cnt = 0;
		done = 1'b0;
		while (!done && !timed_out) begin
			@(negedge clk);
			if (mst_r[m].rvalid && mst_rready[m]) begin
				if (n == 0) begin
					first_beat[m] = cyc;
				end
				checks++;
				if (mst_r[m].rresp != `RESP_OKAY) begin
					$display("ERROR at %0t: master %0d beat %0d response %0d",
						$time, m, n, mst_r[m].rresp);
					errors++;
				end
				if (in_rtc(addr)) begin
					if (addr[2]) begin
						check_rtc(mst_r[m].rdata);
					end else begin
						rtc_lo = mst_r[m].rdata;
					end
				end else begin
					exp = shadow[idx + n];
					if (mst_r[m].rdata != exp || mst_r[m].rlast != (n == int'(len))) begin
						$display("ERROR at %0t: master %0d beat %0d data %h last %b, expected %h",
							$time, m, n, mst_r[m].rdata, mst_r[m].rlast, exp);
						errors++;
					end
				end
				done = mst_r[m].rlast;
				n++;
				cnt = 0;
			end else begin
				cnt++;
				if (cnt > LIMIT) begin
					note_timeout("read data beat");
				end
			end
			@(posedge clk);
			#2;
			mst_rready[m] = !done && ($random(seed) & 3) != 0;
		end
		checks++;
		if (!timed_out && n != int'(len) + 1) begin
			$display("ERROR at %0t: master %0d got %0d beats, expected %0d",
				$time, m, n, int'(len) + 1);
			errors++;
		end
	endtask

	task automatic write_op(input addr_t addr, input data_t data, input strb_t strb);
		int cnt;
		logic aw_done;
		logic w_done;
		logic b_done;
		shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], data, strb);
		@(posedge clk);
		#2;
		lsu_aw.awaddr  = addr;
		lsu_aw.awvalid = 1'b1;
		lsu_w.wdata    = data;
		lsu_w.wstrb    = strb;
		lsu_w.wvalid   = 1'b1;
		aw_done = 1'b0;
		w_done  = 1'b0;
		cnt = 0;
		while (!(aw_done && w_done) && !timed_out) begin
			@(negedge clk);
			if (lsu_aw.awvalid && lsu_awready) begin
				aw_done = 1'b1;
			end
			if (lsu_w.wvalid && lsu_wready) begin
				w_done = 1'b1;
			end
			cnt++;
			if (cnt > LIMIT) begin
				note_timeout("write address or data handshake");
			end
			@(posedge clk);
			#2;
			if (aw_done) begin
				lsu_aw.awvalid = 1'b0;
			end
			if (w_done) begin
				lsu_w.wvalid = 1'b0;
			end
		end
		lsu_bready = ($random(seed) & 1) != 0;
		b_done = 1'b0;
		cnt = 0;
		while (!b_done && !timed_out) begin
			@(negedge clk);
			if (lsu_b.bvalid && lsu_bready) begin
				b_done = 1'b1;
				checks++;
				if (lsu_b.bresp != `RESP_OKAY) begin
					$display("ERROR at %0t: write response %0d", $time, lsu_b.bresp);
					errors++;
				end
			end
			cnt++;
			if (cnt > LIMIT) begin
				note_timeout("write response");
			end
			@(posedge clk);
			#2;
			lsu_bready = !b_done && ($random(seed) & 1) != 0;
		end
	endtask

	initial begin
		seed = 32'h50d4;
		clk = 1'b0;
		rst = 1'b1;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		prev_rtc = 64'd0;
		rtc_lo = '0;
		for (int m = 0; m < 2; m++) begin
			mst_ar[m] = '0;
			mst_rready[m] = 1'b0;
			first_beat[m] = 0;
		end
		lsu_aw = '0;
		lsu_w = '0;
		lsu_bready = 1'b0;
		soc_arready = 1'b0;
		soc_r = '0;
		soc_awready = 1'b0;
		soc_wready = 1'b0;
		soc_b = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = fill_word(addr_t'(i * 4));
			shadow[i] = mem[i];
		end

		// a both entry reads len 0 on lsu and a 4 beat burst on ifu at addr + 0x100
		set_op(0,  1'b1, 1, 32'h0000_0100, 8'd0, 32'hdead_beef, 4'hf, 1'b0);
		set_op(1,  1'b1, 1, 32'h0000_0104, 8'd0, 32'h1122_3344, 4'h5, 1'b0);
		set_op(2,  1'b0, 1, 32'h0000_0100, 8'd0, 32'h0, 4'h0, 1'b0);
		set_op(3,  1'b0, 1, 32'h0000_0104, 8'd0, 32'h0, 4'h0, 1'b0);
		set_op(4,  1'b0, 0, 32'h0000_0200, 8'd3, 32'h0, 4'h0, 1'b0);
		set_op(5,  1'b0, 1, 32'ha000_0048, 8'd0, 32'h0, 4'h0, 1'b0);
		set_op(6,  1'b0, 1, 32'ha000_004c, 8'd0, 32'h0, 4'h0, 1'b0);
		set_op(7,  1'b1, 1, 32'h0000_0108, 8'd0, 32'hcafe_f00d, 4'h6, 1'b0);
		set_op(8,  1'b0, 1, 32'h0000_0104, 8'd0, 32'h0, 4'h0, 1'b1);
		set_op(9,  1'b0, 1, 32'ha000_0048, 8'd0, 32'h0, 4'h0, 1'b0);
		set_op(10, 1'b0, 1, 32'ha000_004c, 8'd0, 32'h0, 4'h0, 1'b0);
		set_op(11, 1'b0, 0, 32'h0000_0100, 8'd3, 32'h0, 4'h0, 1'b0);

		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		for (int i = 0; i < N_OPS && !timed_out; i++) begin
			if (op_write[i]) begin
				write_op(op_addr[i], op_data[i], op_strb[i]);
			end else if (op_both[i]) begin
				fork
					read_op(1, op_addr[i], op_len[i]);
					read_op(0, op_addr[i] + 32'h100, 8'd3);
				join
				checks++;
				if (!timed_out && first_beat[1] >= first_beat[0]) begin
					$display("ERROR at %0t: lsu first beat at cycle %0d, ifu at %0d",
						$time, first_beat[1], first_beat[0]);
					errors++;
				end
			end else begin
				read_op(op_master[i], op_addr[i], op_len[i]);
			end
		end

		$display("checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+common
common/axi_pkg.sv
arbiter/axi_read_arbiter.sv
xbar/axi_xbar.sv
verilog/rtc_timer.sv
verilog/mem_subsys_top.sv
testbench/mem_subsys_assert.sv
testbench/tb_mem_subsys.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mem_subsys
FILELIST = all.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

SOURCES  = $(shell grep -v '^+' $(FILELIST))
HEADERS  = $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the exit status comes from the search for the pass line
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
